//--- logic/vi_macros.svh
`ifndef VI_MACROS_SVH
`define VI_MACROS_SVH

// ------------------------------------------------
// widths fixed by the pixel format
// ------------------------------------------------

// counters and every timing field
`define VI_COORD_W   12

// one colour channel of the internal rgb888 pixel
`define VI_CH_W      8

// packed rgb565 output word
`define VI_PIX_W     16

// ------------------------------------------------
// test pattern geometry
// ------------------------------------------------

// low coordinate bits that are zero on a grid line, 32 px spacing
`define VI_GRID_W    5

// bar width is h_res >> this, eight bars per line
`define VI_BARS_LOG2 3

`endif

//--- logic/vi_pkg.sv
`include "vi_macros.svh"

package vi_pkg;

    // ------------------------------------------------
    // plain vectors
    // ------------------------------------------------
    typedef logic [`VI_COORD_W-1:0] coord_t;   // counts, coordinates, timing fields
    typedef logic [`VI_CH_W-1:0]    chan_t;    // 8-bit colour channel
    typedef logic [`VI_PIX_W-1:0]   pix565_t;  // {r5, g6, b5}

    // pattern select, codes 4..7 all draw blue
    typedef enum logic [2:0] {
        PAT_BAR    = 3'd0,  // eight colour bars
        PAT_GRID   = 3'd1,  // red 32 px grid on black
        PAT_GRAY   = 3'd2,  // horizontal ramp
        PAT_SINGLE = 3'd3,  // programmed colour
        PAT_BLUE   = 3'd4   // fallback
    } pattern_mode_t;

    // ------------------------------------------------
    // bundles
    // ------------------------------------------------
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb888_t;

    // one programmable timing set, 97 bits
    typedef struct packed {
        coord_t h_total;
        coord_t h_sync;
        coord_t h_bporch;
        coord_t h_res;
        coord_t v_total;
        coord_t v_sync;
        coord_t v_bporch;
        coord_t v_res;
        logic   vs_pol;   // 1 = vsync active high on the output
    } video_timing_t;

    typedef struct packed {
        logic   de;
        logic   vs;       // active high here
        coord_t x;        // offset inside the active window
        coord_t y;
    } pixel_pos_t;

    // external input and final output
    typedef struct packed {
        logic    vs;
        logic    de;
        pix565_t data;
    } video_bus_t;

endpackage

//--- logic/video_timing.sv
`timescale 1ns/1ps

module video_timing
    import vi_pkg::*;
(
    input  logic          I_pxl_clk,
    input  logic          I_rst_n,
    input  video_timing_t timing,
    output pixel_pos_t    pos
);

    coord_t h_cnt;      // raw horizontal position
    coord_t v_cnt;      // raw line number
    coord_t h_start;    // first active column
    coord_t h_end;      // last active column
    coord_t v_start;
    coord_t v_end;
    logic   h_last;
    logic   v_last;
    logic   h_act;
    logic   v_act;
    logic   vs_act;

    // ------------------------------------------------
    // raw counters
    // ------------------------------------------------
    // >= so a shrinking total never leaves the counter stuck high
    assign h_last = (h_cnt >= timing.h_total - 1'b1);
    assign v_last = (v_cnt >= timing.v_total - 1'b1);

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;              // wrap at end of line
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            v_cnt <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt <= '0;          // new frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // active window
    // ------------------------------------------------
    assign h_start = timing.h_sync + timing.h_bporch;
    assign h_end   = h_start + timing.h_res - 1'b1;
    assign v_start = timing.v_sync + timing.v_bporch;
    assign v_end   = v_start + timing.v_res - 1'b1;

    assign h_act  = (h_cnt >= h_start) && (h_cnt <= h_end);
    assign v_act  = (v_cnt >= v_start) && (v_cnt <= v_end);
    assign vs_act = (v_cnt < timing.v_sync);  // sync lines lead the frame

    // registered position, one cycle behind the counters
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            pos <= '0;
        end else begin
            pos.de <= h_act && v_act;
            pos.vs <= vs_act;
            pos.x  <= h_cnt - h_start;  // only meaningful while de
            pos.y  <= v_cnt - v_start;
        end
    end

endmodule

//--- logic/pattern_gen.sv
`timescale 1ns/1ps
`include "vi_macros.svh"

module pattern_gen
    import vi_pkg::*;
(
    input  logic          I_pxl_clk,
    input  logic          I_rst_n,
    input  pixel_pos_t    pos,
    input  pattern_mode_t mode,
    input  coord_t        h_res,
    input  coord_t        v_res,
    input  rgb888_t       single_color,
    output logic          pat_vs,
    output logic          pat_de,
    output rgb888_t       pat_pix
);

    localparam rgb888_t c_white   = '{r: 8'hff, g: 8'hff, b: 8'hff};
    localparam rgb888_t c_yellow  = '{r: 8'hff, g: 8'hff, b: 8'h00};
    localparam rgb888_t c_cyan    = '{r: 8'h00, g: 8'hff, b: 8'hff};
    localparam rgb888_t c_green   = '{r: 8'h00, g: 8'hff, b: 8'h00};
    localparam rgb888_t c_magenta = '{r: 8'hff, g: 8'h00, b: 8'hff};
    localparam rgb888_t c_red     = '{r: 8'hff, g: 8'h00, b: 8'h00};
    localparam rgb888_t c_black   = '{r: 8'h00, g: 8'h00, b: 8'h00};
    localparam rgb888_t c_blue    = '{r: 8'h00, g: 8'h00, b: 8'hff};

    coord_t                    bar_w;      // pixels per bar
    coord_t                    bar_bnd;    // x where the next bar starts
    coord_t                    bar_bnd_c;
    logic [`VI_BARS_LOG2-1:0]  bar_idx;    // bar of the previous active pixel
    logic [`VI_BARS_LOG2-1:0]  bar_idx_c;  // bar of the incoming pixel
    logic                      h_grid_c;
    logic                      v_grid_c;

    logic                      s1_de;
    logic                      s1_vs;
    logic [`VI_BARS_LOG2-1:0]  s1_bar;
    logic                      s1_hgrid;
    logic                      s1_vgrid;
    chan_t                     s1_gray;
    rgb888_t                   pix_c;

    function automatic rgb888_t bar_color(input logic [`VI_BARS_LOG2-1:0] idx);
        case (idx)
            3'd0:    return c_white;
            3'd1:    return c_yellow;
            3'd2:    return c_cyan;
            3'd3:    return c_green;
            3'd4:    return c_magenta;
            3'd5:    return c_red;
            3'd6:    return c_black;
            default: return c_blue;
        endcase
    endfunction

    // ------------------------------------------------
    // stage one, bar index, grid flags, gray level
    // ------------------------------------------------
    assign bar_w = h_res >> `VI_BARS_LOG2;

    always_comb begin
        bar_idx_c = bar_idx;
        bar_bnd_c = bar_bnd;
        if (pos.x == '0) begin
            bar_idx_c = '0;                    // line start
            bar_bnd_c = bar_w;
        end else if ((pos.x == bar_bnd) && (bar_idx != '1)) begin
            bar_idx_c = bar_idx + 1'b1;        // crossed a boundary, sat at 7
            bar_bnd_c = bar_bnd + bar_w;
        end
    end

    // grid on every 32nd coordinate plus the last column / row
    assign h_grid_c = (pos.x[`VI_GRID_W-1:0] == '0) || (pos.x == h_res - 1'b1);
    assign v_grid_c = (pos.y[`VI_GRID_W-1:0] == '0) || (pos.y == v_res - 1'b1);

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            s1_de   <= 1'b0;
            s1_vs   <= 1'b0;
            bar_idx <= '0;
            bar_bnd <= '0;
        end else begin
            s1_de <= pos.de;
            s1_vs <= pos.vs;
            if (pos.de) begin                  // hold state through blanking
                bar_idx <= bar_idx_c;
                bar_bnd <= bar_bnd_c;
            end
        end
    end

    always_ff @(posedge I_pxl_clk) begin
        s1_bar   <= bar_idx_c;
        s1_hgrid <= h_grid_c;
        s1_vgrid <= v_grid_c;
        s1_gray  <= pos.x[`VI_CH_W-1:0];       // ramp wraps every 256 px
    end

    // ------------------------------------------------
    // stage two, colour per mode
    // ------------------------------------------------
    always_comb begin
        pix_c = c_black;                       // blanking stays black
        if (s1_de) begin
            case (mode)
                PAT_BAR:    pix_c = bar_color(s1_bar);
                PAT_GRID:   pix_c = (s1_hgrid || s1_vgrid) ? c_red : c_black;
                PAT_GRAY:   pix_c = '{r: s1_gray, g: s1_gray, b: s1_gray};
                PAT_SINGLE: pix_c = single_color;
                default:    pix_c = c_blue;    // PAT_BLUE and codes 5..7
            endcase
        end
    end

    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            pat_de  <= 1'b0;
            pat_vs  <= 1'b0;
            pat_pix <= c_black;
        end else begin
            pat_de  <= s1_de;
            pat_vs  <= s1_vs;
            pat_pix <= pix_c;
        end
    end

endmodule

//--- logic/vi_out.sv
`timescale 1ns/1ps
`include "vi_macros.svh"

module vi_out
    import vi_pkg::*;
(
    input  logic       I_pxl_clk,
    input  logic       I_rst_n,
    input  logic       src_sel,   // 1 = external stream
    input  logic       vs_pol,    // output vsync polarity
    input  logic       pat_vs,
    input  logic       pat_de,
    input  rgb888_t    pat_pix,
    input  video_bus_t ext,
    output video_bus_t vi
);

    video_bus_t pat_bus;   // vs kept active high
    video_bus_t ext_bus;
    video_bus_t sel_bus;
    video_bus_t bus_q;     // output register, vs stored active high

    // ------------------------------------------------
    // pattern side, rgb888 to rgb565
    // ------------------------------------------------
    assign pat_bus.vs   = pat_vs;
    assign pat_bus.de   = pat_de;
    assign pat_bus.data = pix565_t'({pat_pix.r[`VI_CH_W-1 -: 5],
                                     pat_pix.g[`VI_CH_W-1 -: 6],
                                     pat_pix.b[`VI_CH_W-1 -: 5]});

    // ext vs is already at output polarity, undo it here
    // so the xnor after the register restores it unchanged
    assign ext_bus.vs   = ext.vs ~^ vs_pol;
    assign ext_bus.de   = ext.de;
    assign ext_bus.data = ext.data;

    assign sel_bus = src_sel ? ext_bus : pat_bus;

    // ------------------------------------------------
    // output register
    // ------------------------------------------------
    always_ff @(posedge I_pxl_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            bus_q <= '0;        // vs inactive, de low, black
        end else begin
            bus_q <= sel_bus;
        end
    end

    // polarity applied after the flop, vs_pol is static config
    assign vi.vs   = bus_q.vs ~^ vs_pol;
    assign vi.de   = bus_q.de;
    assign vi.data = bus_q.data;

endmodule

//--- logic/video_in_top.sv
`timescale 1ns/1ps

module video_in_top
    import vi_pkg::*;
(
    input  logic          I_pxl_clk,
    input  logic          I_rst_n,
    input  logic          src_sel,       // 0 pattern, 1 external
    input  pattern_mode_t mode,
    input  video_timing_t timing,
    input  rgb888_t       single_color,
    input  video_bus_t    ext,           // rgb565 input on the pixel clock
    output video_bus_t    vi
);

    pixel_pos_t pos;       // timing -> pattern
    logic       pat_vs;
    logic       pat_de;
    rgb888_t    pat_pix;

    // counters and active window, pos lags counters by 1
    video_timing u_timing (
        .I_pxl_clk (I_pxl_clk),
        .I_rst_n   (I_rst_n),
        .timing    (timing),
        .pos       (pos)
    );

    // two stage colour pipe
    pattern_gen u_pattern (
        .I_pxl_clk    (I_pxl_clk),
        .I_rst_n      (I_rst_n),
        .pos          (pos),
        .mode         (mode),
        .h_res        (timing.h_res),
        .v_res        (timing.v_res),
        .single_color (single_color),
        .pat_vs       (pat_vs),
        .pat_de       (pat_de),
        .pat_pix      (pat_pix)
    );

    // select, pack, register
    vi_out u_out (
        .I_pxl_clk (I_pxl_clk),
        .I_rst_n   (I_rst_n),
        .src_sel   (src_sel),
        .vs_pol    (timing.vs_pol),
        .pat_vs    (pat_vs),
        .pat_de    (pat_de),
        .pat_pix   (pat_pix),
        .ext       (ext),
        .vi        (vi)
    );

endmodule

//--- test/video_in_assertions.sv
`timescale 1ns/1ps

module video_in_assertions
    import vi_pkg::*;
(
    input logic          I_pxl_clk,
    input logic          I_rst_n,
    input logic          src_sel,
    input video_timing_t timing,
    input video_bus_t    ext,
    input video_bus_t    vi
);

    // --------------------------------------------------
    // output port properties
    // --------------------------------------------------

    // first edge out of reset still shows the idle bus
    a_idle_after_reset: assert property (@(posedge I_pxl_clk)
        $rose(I_rst_n) |-> !vi.de && (vi.data == '0) && (vi.vs == !timing.vs_pol))
        else $error("vi not idle in the first cycle after reset");

    a_pass_through: assert property (@(posedge I_pxl_clk) disable iff (!I_rst_n)
        $past(I_rst_n) && $past(src_sel) && src_sel |-> vi == $past(ext))
        else $error("vi does not follow ext with one cycle delay");

    // blanking is black on the pattern path
    a_blank_black: assert property (@(posedge I_pxl_clk) disable iff (!I_rst_n)
        !$past(src_sel) && !vi.de |-> vi.data == '0)
        else $error("pattern data not black while de is low");

endmodule

bind video_in_top video_in_assertions u_video_in_assertions (
    .I_pxl_clk (I_pxl_clk),
    .I_rst_n   (I_rst_n),
    .src_sel   (src_sel),
    .timing    (timing),
    .ext       (ext),
    .vi        (vi)
);

//--- test/tb_video_in.sv
`timescale 1ns/1ps

module tb_video_in
    import vi_pkg::*;
();

    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int h_total      = 80;
    localparam int h_res        = 64;
    localparam int v_total      = 50;
    localparam int v_sync       = 2;
    localparam int v_res        = 40;
    localparam int bar_w        = 8;    // h_res / 8 bars
    localparam int grid_step    = 32;
    localparam int frame_cycles = h_total * v_total;
    localparam int num_frames   = 10;
    localparam int watchdog_ns  = 2 * 12 * frame_cycles * clk_period;

    logic          I_pxl_clk;
    logic          I_rst_n;
    logic          src_sel;
    pattern_mode_t mode;
    video_timing_t timing;
    rgb888_t       single_color;
    video_bus_t    ext;
    video_bus_t    vi;

    // inputs as seen by the DUT at each rising edge
    logic          rst_q;
    logic          sel_q;
    pattern_mode_t mode_q;
    rgb888_t       color_q;
    video_bus_t    ext_q;

    // output model state
    logic          vs_prev;
    logic          de_prev;
    logic          in_frame;  // inside a pattern frame that began with vs
    int            px;        // de samples since line start
    int            py;        // active lines since vs
    int            vs_len;
    int            samples;
    int            pat_frames;   // frames sent with src_sel low
    int            frames_seen;  // pattern frames opened by a vs edge

    video_in_top dut0 (
        .I_pxl_clk    (I_pxl_clk),
        .I_rst_n      (I_rst_n),
        .src_sel      (src_sel),
        .mode         (mode),
        .timing       (timing),
        .single_color (single_color),
        .ext          (ext),
        .vi           (vi)
    );

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [23:0] bar_rgb(input int idx);
        case (idx)
            0:       return 24'hffffff;  // white
            1:       return 24'hffff00;  // yellow
            2:       return 24'h00ffff;  // cyan
            3:       return 24'h00ff00;  // green
            4:       return 24'hff00ff;  // magenta
            5:       return 24'hff0000;  // red
            6:       return 24'h000000;  // black
            default: return 24'h0000ff;  // blue
        endcase
    endfunction

    // keep the top 5, 6 and 5 bits of r, g and b
    function automatic pix565_t pack565(input logic [23:0] c);
        return {c[23:19], c[15:10], c[7:3]};
    endfunction

    function automatic pix565_t expected_pixel(input logic [2:0] m, input int x, input int y,
                                               input logic [23:0] col);
        logic on_grid;
        on_grid = (x % grid_step == 0) || (x == h_res - 1) ||
                  (y % grid_step == 0) || (y == v_res - 1);
        case (m)
            3'd0:    return pack565(bar_rgb(x / bar_w));
            3'd1:    return on_grid ? 16'hf800 : 16'h0000;
            3'd2:    return pack565({3{8'(x)}});   // gray ramp
            3'd3:    return pack565(col);
            default: return 16'h001f;
        endcase
    endfunction

    task automatic fail_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        $display("Test failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    // one new mode / colour / source per frame
    task automatic new_frame_config();
        mode         = pattern_mode_t'($urandom_range(7, 0));
        single_color = rgb888_t'($urandom);
        src_sel      = $urandom_range(1, 0);
    endtask

    // --------------------------------------------------
    // clock, watchdog, input capture
    // --------------------------------------------------
    initial begin
        I_pxl_clk = 1'b0;
        forever #(clk_period / 2) I_pxl_clk = ~I_pxl_clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before all frames were sent");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    always @(posedge I_pxl_clk) begin
        rst_q   <= I_rst_n;
        sel_q   <= src_sel;
        mode_q  <= mode;
        color_q <= single_color;
        ext_q   <= ext;
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        void'($urandom(32'he36a5aa2));
        I_rst_n     = 1'b0;
        ext         = '0;
        in_frame    = 1'b0;
        vs_prev     = 1'b0;
        de_prev     = 1'b0;
        px          = 0;
        py          = 0;
        vs_len      = 0;
        samples     = 0;
        pat_frames  = 0;
        frames_seen = 0;
        timing   = '{h_total: 12'd80, h_sync: 12'd4, h_bporch: 12'd6, h_res: 12'd64,
                     v_total: 12'd50, v_sync: 12'd2, v_bporch: 12'd3, v_res: 12'd40,
                     vs_pol: 1'b0};
        timing.vs_pol = $urandom_range(1, 0);
        new_frame_config();                     // frame 0 held through reset
        repeat (reset_cycles) @(negedge I_pxl_clk);
        I_rst_n = 1'b1;                         // counters start at line 0
        for (int f = 0; f < num_frames; f++) begin
            if (f > 0) begin
                new_frame_config();             // counters back at line 0 in vsync
            end
            if (!src_sel) begin
                pat_frames++;
            end
            repeat (frame_cycles) begin
                ext = src_sel ? video_bus_t'($urandom) : '0;
                @(negedge I_pxl_clk);
            end
        end
        // last frame has no following vs edge to close it
        if (in_frame) begin
            assert (py == v_res) else fail_value("lines per frame", py, v_res);
        end
        assert (frames_seen == pat_frames)
            else fail_value("pattern frames", frames_seen, pat_frames);
        if (samples > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("no DUT output sample was checked");
            $display("Test failed");
            $fatal(1, "empty run");
        end
    end

    // --------------------------------------------------
    // output checks on the falling edge where vi is stable
    // --------------------------------------------------
    always @(negedge I_pxl_clk) begin
        logic    vs_act;
        pix565_t exp_pix;
        vs_act = (vi.vs == timing.vs_pol);
        if (rst_q && sel_q) begin
            assert (vi === ext_q) else fail_value("pass-through", vi, ext_q);
            samples++;
            if (in_frame) begin
                assert (py == v_res) else fail_value("lines per frame", py, v_res);
            end
            in_frame = 1'b0;                    // pattern frame ends at the switch
        end else if (rst_q) begin
            if (vs_act && !vs_prev) begin
                if (in_frame) begin
                    assert (py == v_res) else fail_value("lines per frame", py, v_res);
                end
                in_frame = 1'b1;
                frames_seen++;
                px       = 0;
                py       = 0;
                vs_len   = 0;
            end
            if (vs_act && in_frame) vs_len++;
            if (!vs_act && vs_prev && in_frame) begin
                assert (vs_len == v_sync * h_total)
                    else fail_value("vsync length", vs_len, v_sync * h_total);
            end
            if (vi.de && in_frame) begin
                exp_pix = expected_pixel(mode_q, px, py, color_q);
                assert (vi.data === exp_pix) else fail_value("pattern pixel", vi.data, exp_pix);
                samples++;
                px++;
            end else if (de_prev && in_frame) begin
                assert (px == h_res) else fail_value("pixels per line", px, h_res);
                px = 0;
                py++;
            end
        end
        vs_prev = vs_act;
        de_prev = vi.de;
    end

endmodule

//--- video_in_top.f
+incdir+logic
logic/vi_pkg.sv
logic/video_timing.sv
logic/pattern_gen.sv
logic/vi_out.sv
logic/video_in_top.sv
test/video_in_assertions.sv
test/tb_video_in.sv

//--- Bender.yml
package:
  name: video_in

export_include_dirs:
  - logic

sources:
  - logic/vi_pkg.sv
  - logic/video_timing.sv
  - logic/pattern_gen.sv
  - logic/vi_out.sv
  - logic/video_in_top.sv
  - target: test
    files:
      - test/video_in_assertions.sv
      - test/tb_video_in.sv
